// ==== async_fifo.f ====
+incdir+hdl
hdl/async_fifo_pkg.sv
hdl/gray_ptr_sync.sv
hdl/async_fifo_dpram.sv
hdl/async_fifo_wr_ctrl.sv
hdl/async_fifo_rd_ctrl.sv
hdl/async_fifo.sv
sim/tb_async_fifo.sv

// ==== hdl/async_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module async_fifo (
    input  wire                          wr_clock,
    input  wire                          rd_clock,
    input  wire                          rd_rst,
    input  wire                          wr_en,
    input  wire async_fifo_pkg::word_t   din,
    output async_fifo_pkg::wr_status_t   wr_status,
    input  wire                          rd_en,
    output logic                         valid,
    output async_fifo_pkg::byte_t        dout,
    output async_fifo_pkg::rd_status_t   rd_status
);

    // ram ports
    logic                   ram_we;
    async_fifo_pkg::waddr_t ram_waddr;
    async_fifo_pkg::word_t  ram_wdata;
    logic                   ram_re;
    async_fifo_pkg::waddr_t ram_raddr;
    async_fifo_pkg::word_t  ram_rdata;

    // pointers before and after the crossings
    async_fifo_pkg::wptr_t  wr_ptr_gray;
    async_fifo_pkg::wptr_t  wr_ptr_sync;
    async_fifo_pkg::wptr_t  rd_ptr_gray;
    async_fifo_pkg::wptr_t  rd_ptr_sync;

    async_fifo_wr_ctrl u_wr_ctrl (
        .wr_clock    (wr_clock),
        .rd_rst      (rd_rst),
        .wr_en       (wr_en),
        .din         (din),
        .rd_ptr_bin  (rd_ptr_sync),
        .wr_ptr_gray (wr_ptr_gray),
        .ram_we      (ram_we),
        .ram_waddr   (ram_waddr),
        .ram_wdata   (ram_wdata),
        .wr_status   (wr_status)
    );

    async_fifo_dpram u_dpram (
        .wr_clock (wr_clock),
        .rd_clock (rd_clock),
        .we       (ram_we),
        .waddr    (ram_waddr),
        .wdata    (ram_wdata),
        .re       (ram_re),
        .raddr    (ram_raddr),
        .rdata    (ram_rdata)
    );

    // write pointer into the read domain
    gray_ptr_sync u_sync_wr2rd (
        .dst_clock (rd_clock),
        .dst_rst   (rd_rst),
        .ptr_gray  (wr_ptr_gray),
        .ptr_bin   (wr_ptr_sync)
    );

    // consumed word pointer back into the write domain
    // held at zero through reset, write side cannot move it before release
    gray_ptr_sync u_sync_rd2wr (
        .dst_clock (wr_clock),
        .dst_rst   (rd_rst),
        .ptr_gray  (rd_ptr_gray),
        .ptr_bin   (rd_ptr_sync)
    );

    async_fifo_rd_ctrl u_rd_ctrl (
        .rd_clock    (rd_clock),
        .rd_rst      (rd_rst),
        .rd_en       (rd_en),
        .wr_ptr_bin  (wr_ptr_sync),
        .ram_rdata   (ram_rdata),
        .ram_re      (ram_re),
        .ram_raddr   (ram_raddr),
        .rd_ptr_gray (rd_ptr_gray),
        .valid       (valid),
        .dout        (dout),
        .rd_status   (rd_status)
    );

endmodule

`default_nettype wire

// ==== hdl/async_fifo_config.svh ====
`ifndef ASYNC_FIFO_CONFIG_SVH
`define ASYNC_FIFO_CONFIG_SVH

// width of one word on the write port
`define AFIFO_WORD_W 32

// width of the read port, one byte per read
`define AFIFO_BYTE_W 8

// bytes carried by one word
`define AFIFO_LANES 4
// bits needed to index a byte inside a word
`define AFIFO_LW 2

// ram depth in words
`define AFIFO_DEPTH 16
// address bits for that depth
`define AFIFO_AW 4

// prog_full is raised from this write count in words upward
`define AFIFO_PROG_FULL 12

// prog_empty is raised at or below this read count in bytes
`define AFIFO_PROG_EMPTY 4

`endif

// ==== hdl/async_fifo_dpram.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "async_fifo_config.svh"

module async_fifo_dpram (
    input  wire                          wr_clock,
    input  wire                          rd_clock,
    input  wire                          we,
    input  wire async_fifo_pkg::waddr_t  waddr,
    input  wire async_fifo_pkg::word_t   wdata,
    input  wire                          re,
    input  wire async_fifo_pkg::waddr_t  raddr,
    output async_fifo_pkg::word_t        rdata
);

    // one full-width word per entry
    // the byte lane is picked downstream
    async_fifo_pkg::word_t mem [`AFIFO_DEPTH];

    // write port, wr_clock domain
    always_ff @(posedge wr_clock) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read port, rd_clock domain
    // rdata keeps the last word read while re is low,
    // the read controller uses that as its prefetch slot
    always_ff @(posedge rd_clock) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/async_fifo_pkg.sv ====
`default_nettype none

`include "async_fifo_config.svh"

package async_fifo_pkg;

    // payload widths
    typedef logic [`AFIFO_WORD_W-1:0] word_t;
    typedef logic [`AFIFO_BYTE_W-1:0] byte_t;

    // ram address, no wrap bit
    typedef logic [`AFIFO_AW-1:0] waddr_t;
    // word pointer with wrap bit, binary or gray
    typedef logic [`AFIFO_AW:0] wptr_t;
    // byte pointer, upper bits are the word pointer
    typedef logic [`AFIFO_AW+`AFIFO_LW:0] rptr_t;

    // occupancy in words and in bytes
    typedef logic [`AFIFO_AW:0] wcount_t;
    typedef logic [`AFIFO_AW+`AFIFO_LW:0] rcount_t;

    // write domain flags and counts
    typedef struct packed {
        logic    full;
        logic    prog_full;
        logic    overflow;
        wcount_t wr_data_count;
        wcount_t wr_data_space;
    } wr_status_t;

    // read domain flags and counts
    typedef struct packed {
        logic    empty;
        logic    prog_empty;
        logic    underflow;
        rcount_t rd_data_count;
        rcount_t rd_data_space;
    } rd_status_t;

    // first-word-fall-through prefetch states
    typedef enum logic [1:0] {
        idle,
        fetch,
        hold
    } prefetch_state_t;

endpackage

`default_nettype wire

// ==== hdl/async_fifo_rd_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "async_fifo_config.svh"

module async_fifo_rd_ctrl (
    input  wire                          rd_clock,
    input  wire                          rd_rst,
    input  wire                          rd_en,
    input  wire async_fifo_pkg::wptr_t   wr_ptr_bin,
    input  wire async_fifo_pkg::word_t   ram_rdata,
    output logic                         ram_re,
    output async_fifo_pkg::waddr_t       ram_raddr,
    output async_fifo_pkg::wptr_t        rd_ptr_gray,
    output logic                         valid,
    output async_fifo_pkg::byte_t        dout,
    output async_fifo_pkg::rd_status_t   rd_status
);

    async_fifo_pkg::prefetch_state_t state;
    async_fifo_pkg::prefetch_state_t state_next;
    // words pulled out of the ram
    async_fifo_pkg::wptr_t           fetch_ptr;
    async_fifo_pkg::wptr_t           fetch_ptr_next;
    // bytes handed out on dout
    async_fifo_pkg::rptr_t           rd_ptr;
    async_fifo_pkg::rptr_t           rd_ptr_next;
    async_fifo_pkg::wptr_t           rd_word_next;
    async_fifo_pkg::rcount_t         count_next;
    // word currently being split into bytes
    async_fifo_pkg::word_t           hold_word;
    logic [`AFIFO_LW-1:0]            lane;
    // ram output register holds a word not yet loaded into hold_word
    logic                            pre_valid;
    logic                            pre_valid_next;
    logic                            avail;
    logic                            take;
    logic                            last;
    logic                            load;

    // unfetched words present in the ram
    assign avail = (fetch_ptr != wr_ptr_bin);

    assign valid = (state == async_fifo_pkg::hold);
    assign take  = rd_en & valid;
    assign lane  = rd_ptr[`AFIFO_LW-1:0];
    // lane count is a power of two, all ones marks the last byte
    assign last  = take & (&lane);

    // hold_word loads right after a fetch, or from the prefetched word at a boundary
    assign load = (state == async_fifo_pkg::fetch) | (last & pre_valid);

    // read the ram when the prefetch slot is free or about to be emptied
    assign ram_re    = avail & ((state != async_fifo_pkg::hold) | ~pre_valid | last);
    assign ram_raddr = fetch_ptr[`AFIFO_AW-1:0];

    assign fetch_ptr_next = fetch_ptr + async_fifo_pkg::wptr_t'(ram_re);
    assign rd_ptr_next    = rd_ptr + async_fifo_pkg::rptr_t'(take);
    assign rd_word_next   = rd_ptr_next[`AFIFO_AW+`AFIFO_LW:`AFIFO_LW];

    // unread bytes, four per written word less the bytes already taken
    assign count_next = async_fifo_pkg::rcount_t'(
        {wr_ptr_bin, {`AFIFO_LW{1'b0}}} - rd_ptr_next);

    always_comb begin
        state_next     = state;
        pre_valid_next = pre_valid;
        case (state)
            async_fifo_pkg::idle: begin
                pre_valid_next = 1'b0;
                if (ram_re) begin
                    state_next = async_fifo_pkg::fetch;
                end
            end
            async_fifo_pkg::fetch: begin
                // ram data is valid now, a read issued here becomes the prefetch
                pre_valid_next = ram_re;
                state_next     = async_fifo_pkg::hold;
            end
            default: begin
                if (last) begin
                    pre_valid_next = pre_valid & ram_re;
                    // nothing prefetched, either wait for a fresh read or go idle
                    if (!pre_valid) begin
                        state_next = ram_re ? async_fifo_pkg::fetch : async_fifo_pkg::idle;
                    end
                end else begin
                    pre_valid_next = pre_valid | ram_re;
                end
            end
        endcase
    end

    always_ff @(posedge rd_clock or posedge rd_rst) begin
        if (rd_rst) begin
            state       <= async_fifo_pkg::idle;
            pre_valid   <= 1'b0;
            fetch_ptr   <= '0;
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
        end else begin
            state       <= state_next;
            pre_valid   <= pre_valid_next;
            fetch_ptr   <= fetch_ptr_next;
            rd_ptr      <= rd_ptr_next;
            // consumed word pointer goes back, the slot frees once all its bytes are out
            rd_ptr_gray <= rd_word_next ^ (rd_word_next >> 1);
        end
    end

    always_ff @(posedge rd_clock) begin
        if (load) begin
            hold_word <= ram_rdata;
        end
    end

    // msb first, lane 0 is the top byte
    always_comb begin
        dout = hold_word[(`AFIFO_LANES - 1 - lane) * `AFIFO_BYTE_W +: `AFIFO_BYTE_W];
    end

    always_ff @(posedge rd_clock or posedge rd_rst) begin
        if (rd_rst) begin
            rd_status.empty         <= 1'b1;
            rd_status.prog_empty    <= 1'b1;
            rd_status.underflow     <= 1'b0;
            rd_status.rd_data_count <= '0;
            rd_status.rd_data_space <=
                async_fifo_pkg::rcount_t'(`AFIFO_DEPTH * `AFIFO_LANES);
        end else begin
            // no more words to fetch from the ram
            rd_status.empty         <= (fetch_ptr_next == wr_ptr_bin);
            rd_status.prog_empty    <= (count_next <= `AFIFO_PROG_EMPTY);
            rd_status.underflow     <= rd_en & ~valid;
            rd_status.rd_data_count <= count_next;
            rd_status.rd_data_space <=
                async_fifo_pkg::rcount_t'(`AFIFO_DEPTH * `AFIFO_LANES - count_next);
        end
    end

    // the word on dout was published by the write side and not yet returned
    assert property (@(posedge rd_clock) disable iff (rd_rst)
        valid |-> (rd_ptr[`AFIFO_AW+`AFIFO_LW:`AFIFO_LW] != wr_ptr_bin));

    // byte pointer moves only on an accepted read within a word already fetched
    assert property (@(posedge rd_clock) disable iff (rd_rst)
        (rd_ptr != $past(rd_ptr)) |->
            $past(rd_en && valid &&
                  (rd_ptr[`AFIFO_AW+`AFIFO_LW:`AFIFO_LW] != fetch_ptr)));

endmodule

`default_nettype wire

// ==== hdl/async_fifo_wr_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "async_fifo_config.svh"

module async_fifo_wr_ctrl (
    input  wire                          wr_clock,
    input  wire                          rd_rst,
    input  wire                          wr_en,
    input  wire async_fifo_pkg::word_t   din,
    input  wire async_fifo_pkg::wptr_t   rd_ptr_bin,
    output async_fifo_pkg::wptr_t        wr_ptr_gray,
    output logic                         ram_we,
    output async_fifo_pkg::waddr_t       ram_waddr,
    output async_fifo_pkg::word_t        ram_wdata,
    output async_fifo_pkg::wr_status_t   wr_status
);

    logic [1:0]              rst_pipe;
    logic                    wr_rst;
    async_fifo_pkg::wptr_t   wr_ptr;
    async_fifo_pkg::wptr_t   wr_ptr_next;
    async_fifo_pkg::wcount_t level_next;

    // write reset asserts with rd_rst and releases two wr_clock edges later
    always_ff @(posedge wr_clock or posedge rd_rst) begin
        if (rd_rst) begin
            rst_pipe <= 2'b11;
        end else begin
            rst_pipe <= {rst_pipe[0], 1'b0};
        end
    end

    assign wr_rst = rst_pipe[1];

    // accepted write, full is registered so this has no path from rd side
    assign ram_we    = wr_en & ~wr_status.full & ~wr_rst;
    assign ram_waddr = wr_ptr[`AFIFO_AW-1:0];
    assign ram_wdata = din;

    assign wr_ptr_next = wr_ptr + async_fifo_pkg::wptr_t'(ram_we);

    // words held after this edge, as seen against the returned read pointer
    // the read pointer only lags, so this never underestimates
    assign level_next = async_fifo_pkg::wcount_t'(wr_ptr_next - rd_ptr_bin);

    // binary pointer plus a registered gray copy for the crossing
    always_ff @(posedge wr_clock or posedge wr_rst) begin
        if (wr_rst) begin
            wr_ptr      <= '0;
            wr_ptr_gray <= '0;
        end else begin
            wr_ptr      <= wr_ptr_next;
            wr_ptr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);
        end
    end

    // flags and counts, all from the same next-level value
    always_ff @(posedge wr_clock or posedge wr_rst) begin
        if (wr_rst) begin
            wr_status.full          <= 1'b0;
            wr_status.prog_full     <= 1'b0;
            wr_status.overflow      <= 1'b0;
            wr_status.wr_data_count <= '0;
            wr_status.wr_data_space <= async_fifo_pkg::wcount_t'(`AFIFO_DEPTH);
        end else begin
            wr_status.full          <= (level_next == `AFIFO_DEPTH);
            wr_status.prog_full     <= (level_next >= `AFIFO_PROG_FULL);
            // one cycle pulse for a write that was dropped
            wr_status.overflow      <= wr_en & wr_status.full;
            wr_status.wr_data_count <= level_next;
            wr_status.wr_data_space <=
                async_fifo_pkg::wcount_t'(`AFIFO_DEPTH - level_next);
        end
    end

    // no write lands while full, so an unread ram word is never overwritten
    assert property (@(posedge wr_clock) disable iff (wr_rst)
        ram_we |-> (async_fifo_pkg::wcount_t'(wr_ptr - rd_ptr_bin) < `AFIFO_DEPTH));

    // overflow only echoes a dropped wr_en that left the write pointer in place
    assert property (@(posedge wr_clock) disable iff (wr_rst)
        wr_status.overflow |-> ($past(wr_en) && $stable(wr_ptr)));

endmodule

`default_nettype wire

// ==== hdl/gray_ptr_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module gray_ptr_sync (
    input  wire                          dst_clock,
    input  wire                          dst_rst,
    input  wire async_fifo_pkg::wptr_t   ptr_gray,
    output async_fifo_pkg::wptr_t        ptr_bin
);

    localparam int ptr_w = $bits(async_fifo_pkg::wptr_t);

    // first stage may go metastable, second stage is the usable copy
    async_fifo_pkg::wptr_t meta_q;
    async_fifo_pkg::wptr_t sync_q;

    // source is gray coded so at most one bit moves per source clock
    always_ff @(posedge dst_clock or posedge dst_rst) begin
        if (dst_rst) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= ptr_gray;
            sync_q <= meta_q;
        end
    end

    // gray to binary
    // each binary bit is the xor of all gray bits at and above it
    always_comb begin
        for (int i = 0; i < ptr_w; i++) begin
            ptr_bin[i] = ^(sync_q >> i);
        end
    end

endmodule

`default_nettype wire

// ==== sim/async_fifo_trace.txt ====
# op  value(hex)  test ; value is a data word, a byte count, wr_clock cycles to wait,
# or the expected wr_status_t / rd_status_t packed as in async_fifo_pkg
wait  00000002  reset
wstat 00000010  reset
rstat 00018040  reset
write 3a91c4e7  fill
write 5f0e2b18  fill
write c47d9a03  fill
write 81b6e55c  fill
write 0e2f7791  fill
write d9a4306b  fill
write 6c15f8e2  fill
write a37b0c4d  fill
write 12e8d6f9  fill
write f4506a27  fill
write 7bc93e10  fill
write 28d1a5b6  fill
write e06f4c83  fill
write 9547b21e  fill
write 4be8137a  fill
write b21c69d5  fill
wait  0000000a  fill
wstat 00001a00  fill
rstat 00002000  fill
over  0badf00d  fill
read  00000010  counts
wait  0000000a  counts
wstat 00000984  counts
rstat 00001810  counts
read  0000002b  counts
wait  0000000a  counts
wstat 0000004e  counts
rstat 000102bb  counts
read  00000001  counts
wait  0000000a  counts
wstat 0000002f  counts
rstat 0001823c  counts
read  00000004  drain
under 00000000  drain
wait  0000000a  drain
wstat 00000010  drain
rstat 00018040  drain
write 6e3fa085  wrap
write c8127b4f  wrap
write 1d9e56a3  wrap
read  0000000c  wrap
wait  0000000a  wrap
wstat 00000010  wrap
rstat 00018040  wrap

// ==== sim/tb_async_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "async_fifo_config.svh"

module tb_async_fifo;

    logic                        wr_clock;
    logic                        rd_clock;
    logic                        rd_rst;
    logic                        wr_en;
    logic                        rd_en;
    logic                        valid;
    async_fifo_pkg::word_t       din;
    async_fifo_pkg::byte_t       dout;
    async_fifo_pkg::wr_status_t  wr_status;
    async_fifo_pkg::rd_status_t  rd_status;

    // trace operations as loaded, one entry per line
    string                       ops[$];
    string                       tags[$];
    logic [31:0]                 vals[$];
    // reference model, front is the next byte expected on dout
    async_fifo_pkg::byte_t       model[$];
    string                       cur_test;
    int                          test_errs;
    int                          pass_count;
    int                          fail_count;
    int                          cycles;
    int                          limit;
    logic [31:0]                 lcg_state;

    async_fifo dut0 (.*);

    // read clock 20 ns, write clock 30 ns
    always #10 rd_clock = ~rd_clock;
    always #15 wr_clock = ~wr_clock;

    // run limit, armed once the trace length is known
    always @(posedge rd_clock) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("run timed out after %0d read clock cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // idle din values
    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_check(bit ok, string name, string exp_s, string act_s);
        if (ok) begin
            pass_count++;
        end else begin
            $display("CHECK FAILED %s expected %s actual %s", name, exp_s, act_s);
            fail_count++;
            test_errs++;
        end
    endtask

    task automatic check_byte(string name, async_fifo_pkg::byte_t exp,
                              async_fifo_pkg::byte_t act);
        report_check(act === exp, name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_wr_status(string name, async_fifo_pkg::wr_status_t exp,
                                   async_fifo_pkg::wr_status_t act);
        report_check(act === exp, name, $sformatf("%p", exp), $sformatf("%p", act));
    endtask

    task automatic check_rd_status(string name, async_fifo_pkg::rd_status_t exp,
                                   async_fifo_pkg::rd_status_t act);
        report_check(act === exp, name, $sformatf("%p", exp), $sformatf("%p", act));
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        report_check(act === exp, name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    // one write attempt, refused when the FIFO is expected full
    task automatic drive_write(async_fifo_pkg::word_t w, logic expect_full);
        logic was_full;
        @(negedge wr_clock);
        was_full = wr_status.full;
        check_bit({cur_test, " full"}, expect_full, was_full);
        wr_en = 1'b1;
        din   = w;
        @(negedge wr_clock);
        wr_en     = 1'b0;
        lcg_state = lcg_next(lcg_state);
        din       = lcg_state;
        check_bit({cur_test, " overflow"}, expect_full, wr_status.overflow);
        // accepted word splits msb first
        if (!was_full) begin
            for (int i = `AFIFO_LANES - 1; i >= 0; i--) begin
                model.push_back(w[i * `AFIFO_BYTE_W +: `AFIFO_BYTE_W]);
            end
        end
    endtask

    // rd_en only goes high over an edge where valid is already high
    task automatic take_bytes(int n);
        int left;
        left = n;
        while (left > 0) begin
            @(negedge rd_clock);
            rd_en = 1'b0;
            if (valid) begin
                if (model.size() == 0) begin
                    $display("%s: valid is high but no byte is left to read", cur_test);
                    fail_count++;
                    test_errs++;
                end else begin
                    check_byte({cur_test, " dout"}, model.pop_front(), dout);
                end
                rd_en = 1'b1;
                left--;
            end
        end
        @(negedge rd_clock);
        rd_en = 1'b0;
    endtask

    task automatic read_when_empty();
        @(negedge rd_clock);
        check_bit({cur_test, " valid"}, 1'b0, valid);
        rd_en = 1'b1;
        @(negedge rd_clock);
        rd_en = 1'b0;
        check_bit({cur_test, " underflow"}, 1'b1, rd_status.underflow);
    endtask

    task automatic finish_test();
        if (cur_test != "") begin
            $display("test %s finished with %0d errors", cur_test, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic load_trace(int fd);
        string       line;
        string       op;
        string       tag;
        logic [31:0] val;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // skip comments and blank lines
            if (line.len() > 1 && line.getc(0) != "#") begin
                if ($sscanf(line, "%s %h %s", op, val, tag) == 3) begin
                    ops.push_back(op);
                    vals.push_back(val);
                    tags.push_back(tag);
                end else begin
                    $display("trace line not understood: %s", line);
                    fail_count++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_trace();
        async_fifo_pkg::rd_status_t rexp;
        for (int i = 0; i < ops.size(); i++) begin
            // a new tag closes the previous test
            if (tags[i] != cur_test) begin
                finish_test();
                cur_test = tags[i];
            end
            if (ops[i] == "write") begin
                drive_write(vals[i], 1'b0);
            end else if (ops[i] == "over") begin
                drive_write(vals[i], 1'b1);
            end else if (ops[i] == "read") begin
                take_bytes(vals[i]);
            end else if (ops[i] == "under") begin
                read_when_empty();
            end else if (ops[i] == "wait") begin
                repeat (vals[i]) @(negedge wr_clock);
            end else if (ops[i] == "wstat") begin
                @(negedge wr_clock);
                check_wr_status({cur_test, " wr_status"}, async_fifo_pkg::wr_status_t'(
                    vals[i][$bits(async_fifo_pkg::wr_status_t)-1:0]), wr_status);
            end else if (ops[i] == "rstat") begin
                rexp = async_fifo_pkg::rd_status_t'(
                    vals[i][$bits(async_fifo_pkg::rd_status_t)-1:0]);
                @(negedge rd_clock);
                check_rd_status({cur_test, " rd_status"}, rexp, rd_status);
                // no unread byte left, so nothing may be offered on dout
                if (rexp.rd_data_count == 0) begin
                    check_bit({cur_test, " valid"}, 1'b0, valid);
                end
            end else begin
                $display("unknown trace operation %s", ops[i]);
                fail_count++;
            end
        end
        finish_test();
    endtask

    initial begin
        int fd;
        wr_clock   = 1'b0;
        rd_clock   = 1'b0;
        rd_rst     = 1'b1;
        wr_en      = 1'b0;
        rd_en      = 1'b0;
        lcg_state  = 32'd74993;
        din        = lcg_state;
        cur_test   = "";
        test_errs  = 0;
        pass_count = 0;
        fail_count = 0;
        cycles     = 0;
        limit      = 0;
        fd = $fopen("sim/async_fifo_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file sim/async_fifo_trace.txt");
            $display("Checks failed");
            $finish;
        end else begin
            load_trace(fd);
            limit = ops.size() * 10 + 200;
            // reset for three read clocks, released on a falling edge
            repeat (3) @(posedge rd_clock);
            @(negedge rd_clock);
            rd_rst = 1'b0;
            run_trace();
            if (model.size() != 0) begin
                $display("%0d written bytes were never read", model.size());
                fail_count++;
            end
            $display("summary: %0d passed, %0d failed", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
